//--- all.f
+incdir+tests
common/dbg_mem_pkg.sv
rtl/dbg_bus_decode.sv
rtl/dbg_cmd_ctrl.sv
rtl/dbg_abstract_gen.sv
rtl/dbg_mem_response.sv
rtl/dbg_mem_top.sv
tests/tb_dbg_mem.sv

//--- common/dbg_mem_pkg.sv
package dbg_mem_pkg;

  // --------------------
  // sizes
  localparam int unsigned NrHarts     = 4;
  localparam int unsigned HartSelLen  = 2;
  localparam int unsigned BusWidth    = 32;
  localparam int unsigned BeWidth     = 4;
  localparam int unsigned DbgAddrBits = 12;
  localparam int unsigned DataCount   = 2;
  localparam int unsigned AbsCmdWords = 8;

  // --------------------
  // address map, low 12 bits of the zero page
  localparam logic [DbgAddrBits-1:0] HaltedAddr    = 12'h100;
  localparam logic [DbgAddrBits-1:0] GoingAddr     = 12'h108;
  localparam logic [DbgAddrBits-1:0] ResumingAddr  = 12'h110;
  localparam logic [DbgAddrBits-1:0] ExceptionAddr = 12'h118;
  localparam logic [DbgAddrBits-1:0] WhereToAddr   = 12'h300;
  localparam logic [DbgAddrBits-1:0] DataAddr      = 12'h380;
  localparam logic [DbgAddrBits-1:0] DataEndAddr   = DataAddr + DbgAddrBits'(4 * DataCount - 1);
  // program sits right below the data registers
  localparam logic [DbgAddrBits-1:0] AbsCmdAddr    = DataAddr - DbgAddrBits'(4 * AbsCmdWords);
  localparam logic [DbgAddrBits-1:0] AbsCmdEndAddr = DataAddr - DbgAddrBits'(1);
  localparam logic [DbgAddrBits-1:0] FlagsBase     = 12'h400;
  localparam logic [DbgAddrBits-1:0] FlagsEnd      = 12'h7FF;
  localparam logic [DbgAddrBits-1:0] ResumeAddr    = 12'h804;

  // --------------------
  // types
  typedef enum logic [3:0] {
    RegNone, RegHalted, RegGoing, RegResuming, RegException,
    RegWhereTo, RegData, RegAbsCmd, RegFlags
  } region_e;

  typedef enum logic [7:0] {
    AccessRegister = 8'd0,
    QuickAccess    = 8'd1,
    AccessMemory   = 8'd2
  } cmdtype_e;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4
  } cmderr_e;

  typedef enum logic [1:0] { Idle, Go, Resume, CmdExecuting } ctrl_state_e;

  // access register control field, top bit reserved
  typedef struct packed {
    logic        zero1;
    logic [2:0]  aarsize;
    logic        aarpostincrement;
    logic        postexec;
    logic        transfer;
    logic        write;
    logic [15:0] regno;
  } ac_ar_t;

  typedef struct packed {
    cmdtype_e    cmdtype;
    logic [23:0] control;
  } command_t;

  typedef struct packed {
    logic                req;
    logic                we;
    logic [BusWidth-1:0] addr;
    logic [BusWidth-1:0] wdata;
    logic [BeWidth-1:0]  be;
  } bus_req_t;

  // one decoded bus access
  typedef struct packed {
    region_e               region;
    logic                  we;
    logic [HartSelLen-1:0] hart;
    logic [2:0]            slot;
    logic [BusWidth-1:0]   wdata;
    logic [BeWidth-1:0]    be;
    logic                  err;
  } access_t;

  // --------------------
  // instruction encodings
  function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // size doubles as funct3: lb, lh, lw
  function automatic logic [31:0] load(input logic [2:0] size, input logic [4:0] dest,
                                       input logic [4:0] base, input logic [11:0] offset);
    return {offset, base, size, dest, 7'h03};
  endfunction

  function automatic logic [31:0] store(input logic [2:0] size, input logic [4:0] src,
                                        input logic [4:0] base, input logic [11:0] offset);
    return {offset[11:5], src, base, size, offset[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] ebreak();
    return 32'h0010_0073;
  endfunction

  // addi x0, x0, 0
  function automatic logic [31:0] nop();
    return 32'h0000_0013;
  endfunction

endpackage

//--- rtl/dbg_abstract_gen.sv
`timescale 1ns/1ps

module dbg_abstract_gen (
  input  dbg_mem_pkg::command_t                        cmd_i,
  output logic [dbg_mem_pkg::AbsCmdWords-1:0][31:0]    prog_o,
  output logic                                         unsupported_o
);
  import dbg_mem_pkg::*;

  // zero page, so x0 serves as load and store base
  localparam logic [4:0] BaseReg = 5'd0;

  ac_ar_t ac_ar;
  logic   unsupported;

  assign ac_ar = ac_ar_t'(cmd_i.control);

  // --------------------
  // command checks
  always_comb begin
    unsupported = 1'b0;
    // quick access and memory access are not implemented
    if (cmd_i.cmdtype != AccessRegister) unsupported = 1'b1;
    // 64 and 128 bit accesses
    if (ac_ar.aarsize >= 3'd3) unsupported = 1'b1;
    if (ac_ar.aarpostincrement) unsupported = 1'b1;
    // no program buffer behind the command
    if (ac_ar.postexec) unsupported = 1'b1;
    // reserved regno range
    if (ac_ar.regno[15:14] != 2'b00) unsupported = 1'b1;
    // csr space
    if (!ac_ar.regno[12]) unsupported = 1'b1;
    // fpr space
    if (ac_ar.regno[5]) unsupported = 1'b1;
  end

  // --------------------
  // program words
  always_comb begin
    prog_o    = '0;
    prog_o[0] = nop();
    prog_o[1] = nop();
    prog_o[2] = ebreak();
    if (unsupported || !ac_ar.transfer) begin
      // leave right away
      prog_o[0] = ebreak();
    end else if (ac_ar.write) begin
      // data register into gpr
      prog_o[1] = load(ac_ar.aarsize, ac_ar.regno[4:0], BaseReg, DataAddr);
    end else begin
      // gpr into data register
      prog_o[1] = store(ac_ar.aarsize, ac_ar.regno[4:0], BaseReg, DataAddr);
    end
  end

  assign unsupported_o = unsupported;

endmodule

//--- rtl/dbg_bus_decode.sv
`timescale 1ns/1ps

module dbg_bus_decode (
  input  dbg_mem_pkg::bus_req_t bus_i,
  output dbg_mem_pkg::access_t  access_o
);
  import dbg_mem_pkg::*;

  logic [DbgAddrBits-1:0] addr;
  logic [DbgAddrBits-1:0] data_off;
  logic [DbgAddrBits-1:0] abs_off;
  logic [DbgAddrBits-1:0] flag_off;
  region_e                region;
  logic                   err;

  // only the low page bits are decoded
  assign addr     = bus_i.addr[DbgAddrBits-1:0];
  assign data_off = addr - DataAddr;
  assign abs_off  = addr - AbsCmdAddr;
  assign flag_off = addr - FlagsBase;

  always_comb begin
    region = RegNone;
    err    = 1'b0;
    if (bus_i.req) begin
      unique case (addr) inside
        HaltedAddr:                 region = RegHalted;
        GoingAddr:                  region = RegGoing;
        ResumingAddr:               region = RegResuming;
        ExceptionAddr:              region = RegException;
        WhereToAddr:                region = RegWhereTo;
        [DataAddr:DataEndAddr]:     region = RegData;
        [AbsCmdAddr:AbsCmdEndAddr]: region = RegAbsCmd;
        [FlagsBase:FlagsEnd]:       region = RegFlags;
        default:                    region = RegNone;
      endcase

      unique case (region)
        // unmapped
        RegNone: err = 1'b1;
        // read only windows
        RegWhereTo, RegAbsCmd, RegFlags: err = bus_i.we;
        // flag writes must carry the low byte, it holds the hart index
        RegHalted, RegGoing, RegResuming, RegException: err = bus_i.we && !bus_i.be[0];
        // data registers take any byte mix
        default: err = 1'b0;
      endcase

      if (addr[1:0] != 2'b00) begin
        err = 1'b1;
      end
    end
  end

  // --------------------
  // pack the access, a faulty access has no effect downstream
  always_comb begin
    access_o.region = err ? RegNone : region;
    access_o.we     = bus_i.we;
    access_o.wdata  = bus_i.wdata;
    access_o.be     = bus_i.be;
    access_o.err    = err;
    // writing hart names itself in wdata, polling hart by byte lane
    access_o.hart   = (region == RegFlags) ? flag_off[HartSelLen-1:0]
                                           : bus_i.wdata[HartSelLen-1:0];
    unique case (region)
      RegData:   access_o.slot = data_off[4:2];
      RegAbsCmd: access_o.slot = abs_off[4:2];
      // slot 0 is the word holding the per hart flag bytes
      RegFlags:  access_o.slot = {2'b00, |flag_off[DbgAddrBits-1:2]};
      default:   access_o.slot = 3'd0;
    endcase
  end

endmodule

//--- rtl/dbg_cmd_ctrl.sv
`timescale 1ns/1ps

module dbg_cmd_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  dbg_mem_pkg::access_t            access_i,
  input  logic                            ndmreset_i,
  input  logic [19:0]                     hartsel_i,
  input  logic [dbg_mem_pkg::NrHarts-1:0] haltreq_i,
  input  logic [dbg_mem_pkg::NrHarts-1:0] resumereq_i,
  input  logic                            clear_resumeack_i,
  input  logic                            cmd_valid_i,
  input  logic                            unsupported_i,
  output logic [dbg_mem_pkg::NrHarts-1:0] halted_o,
  output logic [dbg_mem_pkg::NrHarts-1:0] resuming_o,
  // go and resume, only the selected hart bit can be set
  output logic [dbg_mem_pkg::NrHarts-1:0] go_o,
  output logic [dbg_mem_pkg::NrHarts-1:0] resume_o,
  output logic                            cmdbusy_o,
  output logic                            cmderror_valid_o,
  output dbg_mem_pkg::cmderr_e            cmderror_o
);
  import dbg_mem_pkg::*;

  ctrl_state_e           state_d, state_q;
  logic [NrHarts-1:0]    halted_d, halted_q;
  logic [NrHarts-1:0]    resuming_d, resuming_q;
  logic [NrHarts-1:0]    sel_mask;
  logic [HartSelLen-1:0] hartsel;
  logic                  halted_wr, going_wr, resuming_wr, exception_wr;
  logic                  resume_ok;

  assign hartsel  = hartsel_i[HartSelLen-1:0];
  assign sel_mask = {{(NrHarts-1){1'b0}}, 1'b1} << hartsel;

  // flag writes from the harts
  assign halted_wr    = access_i.we && (access_i.region == RegHalted);
  assign going_wr     = access_i.we && (access_i.region == RegGoing);
  assign resuming_wr  = access_i.we && (access_i.region == RegResuming);
  assign exception_wr = access_i.we && (access_i.region == RegException);

  // resume is ignored while halting is requested or the last ack is not cleared
  assign resume_ok = resumereq_i[hartsel] && !resuming_q[hartsel] &&
                     !haltreq_i[hartsel] && halted_q[hartsel];

  // --------------------
  // command and resume FSM
  always_comb begin
    state_d          = state_q;
    cmderror_valid_o = 1'b0;
    cmderror_o       = CmdErrNone;
    unique case (state_q)
      Idle: begin
        if (cmd_valid_i) begin
          if (!halted_q[hartsel]) begin
            cmderror_valid_o = 1'b1;
            cmderror_o       = CmdErrHaltResume;
          end else if (unsupported_i) begin
            cmderror_valid_o = 1'b1;
            cmderror_o       = CmdErrNotSupported;
          end else begin
            state_d = Go;
          end
        end else if (resume_ok) begin
          state_d = Resume;
        end
      end
      // hart picks up the program, then reports going
      Go:           if (going_wr) state_d = CmdExecuting;
      Resume:       if (resuming_q[hartsel]) state_d = Idle;
      CmdExecuting: if (halted_wr && (access_i.hart == hartsel)) state_d = Idle;
      default:      state_d = Idle;
    endcase
    if (exception_wr) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = CmdErrException;
    end
    if (ndmreset_i) state_d = Idle;
  end

  // per hart status bits
  always_comb begin
    halted_d   = halted_q;
    resuming_d = resuming_q;
    if (clear_resumeack_i) resuming_d[hartsel] = 1'b0;
    if (halted_wr) halted_d[access_i.hart] = 1'b1;
    if (resuming_wr) begin
      halted_d[access_i.hart]   = 1'b0;
      resuming_d[access_i.hart] = 1'b1;
    end
    if (ndmreset_i) begin
      halted_d   = '0;
      resuming_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      halted_q   <= '0;
      resuming_q <= '0;
    end else begin
      state_q    <= state_d;
      halted_q   <= halted_d;
      resuming_q <= resuming_d;
    end
  end

  assign cmdbusy_o  = (state_q != Idle);
  assign go_o       = (state_q == Go) ? sel_mask : '0;
  assign resume_o   = (state_q == Resume) ? sel_mask : '0;
  assign halted_o   = halted_q;
  assign resuming_o = resuming_q;

endmodule

//--- rtl/dbg_mem_response.sv
`timescale 1ns/1ps

module dbg_mem_response (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  dbg_mem_pkg::access_t                       access_i,
  input  logic [dbg_mem_pkg::DataCount-1:0][31:0]    data_i,
  input  logic [dbg_mem_pkg::AbsCmdWords-1:0][31:0]  prog_i,
  input  logic [dbg_mem_pkg::NrHarts-1:0]            go_i,
  input  logic [dbg_mem_pkg::NrHarts-1:0]            resume_i,
  input  logic                                       cmdbusy_i,
  output logic [dbg_mem_pkg::DataCount-1:0][31:0]    data_o,
  output logic                                       data_valid_o,
  output logic [dbg_mem_pkg::BusWidth-1:0]           rdata_o,
  output logic                                       err_o
);
  import dbg_mem_pkg::*;

  logic [DataCount-1:0][31:0] data_bits;
  logic [BusWidth-1:0]        rdata_d, rdata_q;
  logic                       err_q;

  // --------------------
  // data register writes, merged byte by byte over data_i
  always_comb begin
    data_bits    = data_i;
    data_valid_o = 1'b0;
    if (access_i.we && (access_i.region == RegData)) begin
      data_valid_o = 1'b1;
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (access_i.be[b]) begin
          data_bits[access_i.slot[0]][b*8 +: 8] = access_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  assign data_o = data_bits;

  // read data, answered next cycle
  always_comb begin
    rdata_d = '0;
    if (!access_i.we) begin
      unique case (access_i.region)
        RegData:   rdata_d = data_i[access_i.slot[0]];
        RegAbsCmd: rdata_d = prog_i[access_i.slot];
        RegFlags: begin
          // one byte per hart, {resume, go} in the low bits
          if (access_i.slot == 3'd0) begin
            for (int unsigned h = 0; h < NrHarts; h++) begin
              rdata_d[h*8 +: 8] = {6'b0, resume_i[h], go_i[h]};
            end
          end
        end
        RegWhereTo: begin
          // resume wins, busy also covers the resume state
          if (|resume_i) begin
            rdata_d = jal(5'd0, 21'(ResumeAddr) - 21'(WhereToAddr));
          end else if (cmdbusy_i) begin
            rdata_d = jal(5'd0, 21'(AbsCmdAddr) - 21'(WhereToAddr));
          end
        end
        default: rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else begin
      rdata_q <= rdata_d;
      err_q   <= access_i.err;
    end
  end

  assign rdata_o = rdata_q;
  assign err_o   = err_q;

endmodule

//--- rtl/dbg_mem_top.sv
`timescale 1ns/1ps

module dbg_mem_top (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           ndmreset_i,
  input  logic [19:0]                                    hartsel_i,
  // run control from the debug module registers
  input  logic [dbg_mem_pkg::NrHarts-1:0]                haltreq_i,
  input  logic [dbg_mem_pkg::NrHarts-1:0]                resumereq_i,
  input  logic                                           clear_resumeack_i,
  output logic [dbg_mem_pkg::NrHarts-1:0]                debug_req_o,
  output logic [dbg_mem_pkg::NrHarts-1:0]                halted_o,
  output logic [dbg_mem_pkg::NrHarts-1:0]                resuming_o,
  // data registers
  input  logic [dbg_mem_pkg::DataCount-1:0][31:0]        data_i,
  output logic [dbg_mem_pkg::DataCount-1:0][31:0]        data_o,
  output logic                                           data_valid_o,
  // abstract command handshake
  input  logic                                           cmd_valid_i,
  input  dbg_mem_pkg::command_t                          cmd_i,
  output logic                                           cmderror_valid_o,
  output dbg_mem_pkg::cmderr_e                           cmderror_o,
  output logic                                           cmdbusy_o,
  // hart side bus
  input  dbg_mem_pkg::bus_req_t                          bus_i,
  output logic [dbg_mem_pkg::BusWidth-1:0]               rdata_o,
  output logic                                           err_o
);
  import dbg_mem_pkg::*;

  access_t                              access;
  logic [AbsCmdWords-1:0][31:0]         prog;
  logic                                 unsupported;
  logic [NrHarts-1:0]                   go;
  logic [NrHarts-1:0]                   resume;

  // halt requests go straight to the harts
  assign debug_req_o = haltreq_i;

  dbg_bus_decode i_decode (
    .bus_i    (bus_i),
    .access_o (access)
  );

  dbg_cmd_ctrl i_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .access_i          (access),
    .ndmreset_i        (ndmreset_i),
    .hartsel_i         (hartsel_i),
    .haltreq_i         (haltreq_i),
    .resumereq_i       (resumereq_i),
    .clear_resumeack_i (clear_resumeack_i),
    .cmd_valid_i       (cmd_valid_i),
    .unsupported_i     (unsupported),
    .halted_o          (halted_o),
    .resuming_o        (resuming_o),
    .go_o              (go),
    .resume_o          (resume),
    .cmdbusy_o         (cmdbusy_o),
    .cmderror_valid_o  (cmderror_valid_o),
    .cmderror_o        (cmderror_o)
  );

  dbg_abstract_gen i_abs_gen (
    .cmd_i         (cmd_i),
    .prog_o        (prog),
    .unsupported_o (unsupported)
  );

  dbg_mem_response i_response (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .access_i     (access),
    .data_i       (data_i),
    .prog_i       (prog),
    .go_i         (go),
    .resume_i     (resume),
    .cmdbusy_i    (cmdbusy_o),
    .data_o       (data_o),
    .data_valid_o (data_valid_o),
    .rdata_o      (rdata_o),
    .err_o        (err_o)
  );

endmodule

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it, a $fatal gives a failing status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tb_dbg_mem -o tb_dbg_mem
./obj_dir/tb_dbg_mem

//--- tests/tb_dbg_model.svh
`ifndef TB_DBG_MODEL_SVH
`define TB_DBG_MODEL_SVH

// --------------------
// model state as the hart side should see it
ctrl_state_e        m_state;
logic [NrHarts-1:0] m_halted;
logic [NrHarts-1:0] m_resuming;

// region of a page offset
function automatic region_e addr_region(input logic [11:0] a);
  if (a == HaltedAddr) return RegHalted;
  if (a == GoingAddr) return RegGoing;
  if (a == ResumingAddr) return RegResuming;
  if (a == ExceptionAddr) return RegException;
  if (a == WhereToAddr) return RegWhereTo;
  // two data words, the program words right below them
  if (a >= DataAddr && a < DataAddr + 12'(4 * DataCount)) return RegData;
  if (a >= AbsCmdAddr && a < DataAddr) return RegAbsCmd;
  if (a >= FlagsBase && a <= FlagsEnd) return RegFlags;
  return RegNone;
endfunction

// bus error for the request on the bus this cycle
function automatic logic access_err();
  region_e r;
  r = addr_region(bus.addr[11:0]);
  if (!bus.req) return 1'b0;
  if (r == RegNone || bus.addr[1:0] != 2'b00) return 1'b1;
  if (!bus.we) return 1'b0;
  // whereto, program and flags are read only
  if (r == RegWhereTo || r == RegAbsCmd || r == RegFlags) return 1'b1;
  // a flag write without its low byte loses the hart id
  return r != RegData && !bus.be[0];
endfunction

// region that a legal write hits, none otherwise
function automatic region_e written_region();
  if (!bus.req || !bus.we || access_err()) return RegNone;
  return addr_region(bus.addr[11:0]);
endfunction

// --------------------
// abstract command rules
function automatic logic cmd_unsupported(input command_t c);
  ac_ar_t ar;
  ar = ac_ar_t'(c.control);
  return c.cmdtype != AccessRegister || ar.aarsize > 3'd2 || ar.aarpostincrement ||
         ar.postexec || ar.regno[15:14] != 2'b00 || !ar.regno[12] || ar.regno[5];
endfunction

function automatic logic [31:0] prog_word(input command_t c, input logic [2:0] idx);
  ac_ar_t ar;
  logic   xfer;
  ar   = ac_ar_t'(c.control);
  xfer = ar.transfer && !cmd_unsupported(c);
  case (idx)
    3'd0: return xfer ? nop() : ebreak();
    3'd1: begin
      if (!xfer) return nop();
      // write moves data0 into the gpr, read the other way round
      if (ar.write) return load(ar.aarsize, ar.regno[4:0], 5'd0, DataAddr);
      return store(ar.aarsize, ar.regno[4:0], 5'd0, DataAddr);
    end
    3'd2: return ebreak();
    default: return 32'h0;
  endcase
endfunction

// read data expected one cycle after the request
function automatic logic [31:0] read_value();
  logic [11:0] a;
  logic [31:0] v;
  a = bus.addr[11:0];
  v = '0;
  if (!bus.req || bus.we || access_err()) return v;
  case (addr_region(a))
    RegData:   v = data_in[a[2]];
    RegAbsCmd: v = prog_word(cmd, 3'((a - AbsCmdAddr) >> 2));
    RegFlags: begin
      // byte per hart, go in bit 0 and resume in bit 1
      if (a == FlagsBase && m_state == Go) v[hartsel[1:0]*8 +: 8] = 8'h01;
      if (a == FlagsBase && m_state == Resume) v[hartsel[1:0]*8 +: 8] = 8'h02;
    end
    RegWhereTo: begin
      if (m_state == Resume) v = jal(5'd0, 21'(ResumeAddr) - 21'(WhereToAddr));
      else if (m_state != Idle) v = jal(5'd0, 21'(AbsCmdAddr) - 21'(WhereToAddr));
    end
    default: v = '0;
  endcase
  return v;
endfunction

// data_o with the enabled bytes of a data write merged in
function automatic logic [DataCount-1:0][31:0] merged_data();
  logic [DataCount-1:0][31:0] d;
  d = data_in;
  if (written_region() == RegData) begin
    for (int unsigned b = 0; b < BeWidth; b++) begin
      if (bus.be[b]) d[bus.addr[2]][b*8 +: 8] = bus.wdata[b*8 +: 8];
    end
  end
  return d;
endfunction

// error that the inputs of this cycle raise
function automatic cmderr_e cmd_error();
  cmderr_e e;
  e = CmdErrNone;
  if (cmd_valid && m_state == Idle) begin
    if (!m_halted[hartsel[1:0]]) e = CmdErrHaltResume;
    else if (cmd_unsupported(cmd)) e = CmdErrNotSupported;
  end
  if (written_region() == RegException) e = CmdErrException;
  return e;
endfunction

// --------------------
// state after the coming clock edge
function automatic void model_advance();
  ctrl_state_e        nxt;
  logic [NrHarts-1:0] h;
  logic [NrHarts-1:0] r;
  region_e            wr;
  logic [1:0]         hs;
  logic [1:0]         wh;
  hs  = hartsel[1:0];
  wh  = bus.wdata[1:0];
  wr  = written_region();
  nxt = m_state;
  h   = m_halted;
  r   = m_resuming;
  case (m_state)
    Idle: begin
      if (cmd_valid) begin
        if (m_halted[hs] && !cmd_unsupported(cmd)) nxt = Go;
      end else if (resumereq[hs] && m_halted[hs] && !m_resuming[hs] && !haltreq[hs]) begin
        nxt = Resume;
      end
    end
    Go:           if (wr == RegGoing) nxt = CmdExecuting;
    Resume:       if (m_resuming[hs]) nxt = Idle;
    CmdExecuting: if (wr == RegHalted && wh == hs) nxt = Idle;
    default:      nxt = Idle;
  endcase
  if (clear_resumeack) r[hs] = 1'b0;
  if (wr == RegHalted) h[wh] = 1'b1;
  if (wr == RegResuming) begin
    h[wh] = 1'b0;
    r[wh] = 1'b1;
  end
  if (ndmreset) begin
    nxt = Idle;
    h   = '0;
    r   = '0;
  end
  m_state    = nxt;
  m_halted   = h;
  m_resuming = r;
endfunction

`endif

//--- tests/tb_dbg_mem.sv
`timescale 1ns/1ps

module tb_dbg_mem;
  import dbg_mem_pkg::*;

  localparam int unsigned NumOps    = 400;
  // no operation comes near eight cycles on average
  localparam int unsigned MaxCycles = NumOps * 8;
  // flag writes first, then whereto, program, data and flags
  localparam logic [11:0] Spots [9] = '{12'h100, 12'h108, 12'h110, 12'h118, 12'h300,
                                        12'h360, 12'h380, 12'h400, 12'h7fc};

  logic                       clk;
  logic                       rst_n;
  logic                       ndmreset;
  logic [19:0]                hartsel;
  logic [NrHarts-1:0]         haltreq;
  logic [NrHarts-1:0]         resumereq;
  logic                       clear_resumeack;
  logic [NrHarts-1:0]         debug_req;
  logic [NrHarts-1:0]         halted;
  logic [NrHarts-1:0]         resuming;
  logic [DataCount-1:0][31:0] data_in;
  logic [DataCount-1:0][31:0] data_out;
  logic                       data_valid;
  logic                       cmd_valid;
  command_t                   cmd;
  logic                       cmderror_valid;
  cmderr_e                    cmderror;
  logic                       cmdbusy;
  bus_req_t                   bus;
  logic [BusWidth-1:0]        rdata;
  logic                       err;
  int unsigned                cycles = 0;

  `include "tb_dbg_model.svh"

  dbg_mem_top i_dbg_mem_top (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .ndmreset_i        (ndmreset),
    .hartsel_i         (hartsel),
    .haltreq_i         (haltreq),
    .resumereq_i       (resumereq),
    .clear_resumeack_i (clear_resumeack),
    .debug_req_o       (debug_req),
    .halted_o          (halted),
    .resuming_o        (resuming),
    .data_i            (data_in),
    .data_o            (data_out),
    .data_valid_o      (data_valid),
    .cmd_valid_i       (cmd_valid),
    .cmd_i             (cmd),
    .cmderror_valid_o  (cmderror_valid),
    .cmderror_o        (cmderror),
    .cmdbusy_o         (cmdbusy),
    .bus_i             (bus),
    .rdata_o           (rdata),
    .err_o             (err)
  );

  always #4 clk = ~clk;

  // watchdog over the whole run
  always @(posedge clk) begin
    if (rst_n) begin
      cycles <= cycles + 1;
      if (cycles >= MaxCycles) begin
        $display("timeout: the run did not end within %0d cycles", MaxCycles);
        $display("Done: errors found");
        $fatal(1);
      end
    end
  end

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  // --------------------
  // comb outputs are checked mid cycle and registered ones after the edge
  task automatic tick();
    logic [31:0] exp_rdata;
    logic        exp_err;
    cmderr_e     exp_cmderr;
    #2;
    exp_rdata  = read_value();
    exp_err    = access_err();
    exp_cmderr = cmd_error();
    check_value("cmderror_valid_o", 64'(exp_cmderr != CmdErrNone), 64'(cmderror_valid));
    check_value("cmderror_o", 64'(exp_cmderr), 64'(cmderror));
    check_value("data_valid_o", 64'(written_region() == RegData), 64'(data_valid));
    check_value("data_o", 64'(merged_data()), 64'(data_out));
    check_value("cmdbusy_o", 64'(m_state != Idle), 64'(cmdbusy));
    check_value("halted_o", 64'(m_halted), 64'(halted));
    check_value("resuming_o", 64'(m_resuming), 64'(resuming));
    check_value("debug_req_o", 64'(haltreq), 64'(debug_req));
    model_advance();
    @(posedge clk);
    #1;
    check_value("rdata_o", 64'(exp_rdata), 64'(rdata));
    check_value("err_o", 64'(exp_err), 64'(err));
    // pulses last one cycle
    bus.req         = 1'b0;
    cmd_valid       = 1'b0;
    resumereq       = '0;
    clear_resumeack = 1'b0;
    ndmreset        = 1'b0;
  endtask

  task automatic bus_access(input logic we, input logic [11:0] addr,
                            input logic [31:0] wdata, input logic [3:0] be);
    bus.req   = 1'b1;
    bus.we    = we;
    // upper bits are outside the page decode
    bus.addr  = {20'($urandom), addr};
    bus.wdata = wdata;
    bus.be    = be;
    tick();
  endtask

  function automatic command_t random_command(input logic legal);
    command_t c;
    ac_ar_t   ar;
    ar          = '0;
    ar.aarsize  = 3'($urandom % 3);
    ar.transfer = 1'($urandom);
    ar.write    = 1'($urandom);
    // gpr space starts at 0x1000
    ar.regno    = 16'h1000 | 16'($urandom % 32);
    c.cmdtype   = AccessRegister;
    // an illegal command breaks exactly one rule
    if (!legal) begin
      case ($urandom % 7)
        0:       c.cmdtype = ($urandom % 2 == 0) ? QuickAccess : AccessMemory;
        1:       ar.aarsize = 3'd3 + 3'($urandom % 5);
        2:       ar.aarpostincrement = 1'b1;
        3:       ar.postexec = 1'b1;
        4:       ar.regno[15:14] = 2'd1 + 2'($urandom % 3);
        5:       ar.regno[12] = 1'b0;
        default: ar.regno[5] = 1'b1;
      endcase
    end
    c.control = ar;
    return c;
  endfunction

  // play the selected hart until the FSM is idle again
  task automatic settle();
    while (cmdbusy) begin
      case (m_state)
        Go:      bus_access(1'b1, GoingAddr, {30'($urandom), hartsel[1:0]}, 4'hf);
        Resume:  bus_access(1'b1, ResumingAddr, {30'($urandom), hartsel[1:0]}, 4'hf);
        default: bus_access(1'b1, HaltedAddr, {30'($urandom), hartsel[1:0]}, 4'hf);
      endcase
    end
  endtask

  // --------------------
  // operations
  task automatic flag_write_op();
    logic [3:0] be;
    be = 4'($urandom);
    // most writes carry the hart byte
    if ($urandom % 4 != 0) be[0] = 1'b1;
    bus_access(1'b1, Spots[$urandom % 4], $urandom, be);
  endtask

  task automatic data_op();
    data_in = {$urandom, $urandom};
    bus_access(1'($urandom), DataAddr + 12'(4 * ($urandom % 2)), $urandom, 4'($urandom));
  endtask

  task automatic random_access_op();
    logic [11:0] a;
    if ($urandom % 2 == 0) a = Spots[$urandom % 9] + 12'($urandom % 8);
    else a = 12'($urandom);
    bus.req   = ($urandom % 8) != 0;
    bus.we    = 1'($urandom);
    bus.addr  = {20'($urandom), a};
    bus.wdata = $urandom;
    bus.be    = 4'($urandom);
    tick();
  endtask

  task automatic hart_event_op();
    case ($urandom % 4)
      0:       ndmreset = 1'b1;
      1:       clear_resumeack = 1'b1;
      default: haltreq = ($urandom % 2 == 0) ? '0 : 4'($urandom);
    endcase
    tick();
  endtask

  task automatic command_op();
    hartsel   = 20'($urandom);
    cmd       = random_command($urandom % 2 == 0);
    cmd_valid = 1'b1;
    tick();
    bus_access(1'b0, AbsCmdAddr + 12'(4 * ($urandom % 8)), '0, '0);
  endtask

  task automatic read_op();
    case ($urandom % 4)
      0:       bus_access(1'b0, WhereToAddr, '0, '0);
      1:       bus_access(1'b0, FlagsBase, '0, '0);
      2:       bus_access(1'b0, AbsCmdAddr + 12'(4 * ($urandom % 8)), '0, '0);
      default: bus_access(1'b0, DataAddr + 12'(4 * ($urandom % 2)), '0, '0);
    endcase
  endtask

  // command from accept to the final halted write
  task automatic run_sequence();
    logic [1:0] h;
    settle();
    h       = 2'($urandom);
    hartsel = {18'($urandom), h};
    bus_access(1'b1, HaltedAddr, {30'($urandom), h}, 4'hf);
    cmd       = random_command(1'b1);
    cmd_valid = 1'b1;
    tick();
    // poll go, fetch the jump and then the load or store word
    bus_access(1'b0, FlagsBase, '0, '0);
    bus_access(1'b0, WhereToAddr, '0, '0);
    bus_access(1'b0, AbsCmdAddr + 12'd4, '0, '0);
    if ($urandom % 4 == 0) bus_access(1'b1, ExceptionAddr, {30'($urandom), h}, 4'h1);
    bus_access(1'b1, GoingAddr, {30'($urandom), h}, 4'hf);
    bus_access(1'b1, HaltedAddr, {30'($urandom), h}, 4'hf);
    tick();
  endtask

  task automatic resume_sequence();
    logic [1:0] h;
    settle();
    h       = 2'($urandom);
    hartsel = {18'($urandom), h};
    bus_access(1'b1, HaltedAddr, {30'($urandom), h}, 4'hf);
    clear_resumeack = 1'b1;
    tick();
    // a pending halt request on this hart blocks the resume
    haltreq   = ($urandom % 4 == 0) ? 4'($urandom) : '0;
    resumereq = (4'b0001 << h) | 4'($urandom);
    tick();
    bus_access(1'b0, FlagsBase, '0, '0);
    bus_access(1'b0, WhereToAddr, '0, '0);
    bus_access(1'b1, ResumingAddr, {30'($urandom), h}, 4'hf);
    tick();
    clear_resumeack = 1'b1;
    tick();
  endtask

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    ndmreset        = 1'b0;
    hartsel         = '0;
    haltreq         = '0;
    resumereq       = '0;
    clear_resumeack = 1'b0;
    data_in         = '0;
    cmd_valid       = 1'b0;
    cmd             = '0;
    bus             = '0;
    m_state         = Idle;
    m_halted        = '0;
    m_resuming      = '0;
    void'($urandom(32'hc7f0_1574));
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // outputs quiet out of reset
    check_value("rdata_o", 64'(0), 64'(rdata));
    check_value("err_o", 64'(0), 64'(err));
    for (int unsigned op = 0; op < NumOps; op++) begin
      case ($urandom % 8)
        0:       flag_write_op();
        1:       data_op();
        2:       random_access_op();
        3:       hart_event_op();
        4:       command_op();
        5:       run_sequence();
        6:       resume_sequence();
        default: read_op();
      endcase
    end
    tick();
    $display("Done: no errors");
    $finish;
  end

endmodule
